// ==== Makefile ====
# Verilator build and run of the drive register testbench
TOP = rpDriveTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/rpDrive.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpDrive (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              clr,
   input  wire                              drvReady,
   input  wire                              req,
   input  wire                              write,
   input  wire  [2:0]                       addr,
   input  wire  [rpRegPkg::DATA_WIDTH-1:0]  wrData,
   output logic                             ack,
   output logic [rpRegPkg::DATA_WIDTH-1:0]  rdData
);

   ////////////////////
   // Internal bus
   ////////////////////

   // Strobes, MR and sector between the blocks
   rpRegBus bus ();

   ////////////////////
   // Blocks
   ////////////////////

   // Host handshake and register decode
   rpRegAccessFsm accessFsm (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .write    (write),
      .addr     (addr),
      .wrData   (wrData),
      .drvReady (drvReady),
      .ack      (ack),
      .rdData   (rdData),
      .bus      (bus.fsm)
   );

   // Maintenance register
   rpMaintReg maintReg (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .drvReady (drvReady),
      .bus      (bus.maint)
   );

   // Sector position
   rpSectorTimer sectorTimer (
      .clk (clk),
      .rst (rst),
      .bus (bus.timer)
   );

endmodule

`default_nettype wire

// ==== hdl/rpMaintReg.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpMaintReg (
   input  wire     clk,
   input  wire     rst,
   input  wire     clr,
   input  wire     drvReady,
   rpRegBus.maint  bus
);

   logic dmd;
   logic dclk;
   logic dind;
   logic dsck;
   logic ddat;

   ////////////////////
   // Diagnostic mode
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dmd <= 1'b0;
      // Controller clear or drive clear
      else if (clr | bus.drvClr)
         dmd <= 1'b0;
      // Only a ready drive may enter diagnostics
      else if (bus.mrWrite & drvReady)
         dmd <= bus.wrData[rpRegPkg::MR_DMD];
   end

   ////////////////////
   // Diagnostic bits
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dclk <= 1'b0;
         dind <= 1'b0;
         dsck <= 1'b0;
         ddat <= 1'b0;
      end
      // Held clear outside diagnostic mode
      else if (!dmd)
      begin
         dclk <= 1'b0;
         dind <= 1'b0;
         dsck <= 1'b0;
         ddat <= 1'b0;
      end
      else if (bus.mrWrite)
      begin
         dclk <= bus.wrData[rpRegPkg::MR_DCLK];
         dind <= bus.wrData[rpRegPkg::MR_DIND];
         dsck <= bus.wrData[rpRegPkg::MR_DSCK];
         ddat <= bus.wrData[rpRegPkg::MR_DDAT];
      end
   end

   // Assemble the MR word
   always_comb
   begin
      bus.mr = '0;
      bus.mr[rpRegPkg::MR_DMD]  = dmd;
      bus.mr[rpRegPkg::MR_DCLK] = dclk;
      bus.mr[rpRegPkg::MR_DIND] = dind;
      bus.mr[rpRegPkg::MR_DSCK] = dsck;
      bus.mr[rpRegPkg::MR_DDAT] = ddat;
   end

endmodule

`default_nettype wire

// ==== hdl/rpRegAccessFsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpRegAccessFsm (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              req,
   input  wire                              write,
   input  wire  [2:0]                       addr,
   input  wire  [rpRegPkg::DATA_WIDTH-1:0]  wrData,
   input  wire                              drvReady,
   output logic                             ack,
   output logic [rpRegPkg::DATA_WIDTH-1:0]  rdData,
   rpRegBus.fsm                             bus
);

   rpTimingPkg::accessState_t state;
   rpTimingPkg::accessState_t nextState;
   logic [rpRegPkg::DATA_WIDTH-1:0] rdValue;
   logic accessCycle;

   ////////////////////
   // Handshake FSM
   ////////////////////

   always_comb
   begin
      nextState = state;
      case (state)
         rpTimingPkg::IDLE:
         begin
            // Host request sampled
            if (req)
               nextState = rpTimingPkg::ACCESS;
         end
         // Single access cycle
         rpTimingPkg::ACCESS:
            nextState = rpTimingPkg::ACKING;
         rpTimingPkg::ACKING:
         begin
            // Hold ack until req drops
            if (!req)
               nextState = rpTimingPkg::IDLE;
         end
         default:
            nextState = rpTimingPkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         state <= rpTimingPkg::IDLE;
      else
         state <= nextState;
   end

   assign accessCycle = (state == rpTimingPkg::ACCESS);
   assign ack         = (state == rpTimingPkg::ACKING);

   ////////////////////
   // Write decode
   ////////////////////

   assign bus.wrData  = wrData;
   // MR load strobe
   assign bus.mrWrite = accessCycle & write & (addr == rpRegPkg::REG_MR);
   // Drive clear through the CS1 function field
   assign bus.drvClr  = accessCycle & write & (addr == rpRegPkg::REG_CS1) &
                        (wrData[rpRegPkg::FUNC_LSB +: rpRegPkg::FUNC_WIDTH] ==
                         rpRegPkg::FUNC_DRVCLR);

   ////////////////////
   // Read mux
   ////////////////////

   always_comb
   begin
      rdValue = '0;
      case (addr)
         rpRegPkg::REG_DS:
         begin
            rdValue[rpRegPkg::DS_DRY] = drvReady;
            rdValue[rpRegPkg::DS_DMD] = bus.mr[rpRegPkg::MR_DMD];
         end
         rpRegPkg::REG_LA:
            rdValue[rpRegPkg::LA_LSB +: rpTimingPkg::SECTOR_WIDTH] = bus.sector;
         rpRegPkg::REG_MR:
            rdValue = rpRegPkg::DATA_WIDTH'(bus.mr);
         // CS1 and unused addresses read zero
         default:
            rdValue = '0;
      endcase
   end

   // Latched at the end of ACCESS and held through ACKING
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rdData <= '0;
      else if (accessCycle & !write)
         rdData <= rdValue;
   end

endmodule

`default_nettype wire

// ==== hdl/rpRegBus.sv ====
`default_nettype none
`timescale 1ns/100ps

interface rpRegBus;

   // Host write data, passed on by the FSM
   logic [rpRegPkg::DATA_WIDTH-1:0] wrData;
   // One-cycle strobes from the FSM
   logic mrWrite;
   logic drvClr;
   // Maintenance register contents
   logic [rpRegPkg::MR_WIDTH-1:0] mr;
   // Current sector
   logic [rpTimingPkg::SECTOR_WIDTH-1:0] sector;

   // Access FSM side
   modport fsm (
      output wrData,
      output mrWrite,
      output drvClr,
      input  mr,
      input  sector
   );

   // Maintenance register side
   modport maint (
      input  wrData,
      input  mrWrite,
      input  drvClr,
      output mr
   );

   // Timer only watches MR
   modport timer (
      input  mr,
      output sector
   );

endinterface

`default_nettype wire

// ==== hdl/rpRegPkg.sv ====
`default_nettype none

package rpRegPkg;

   ////////////////////
   // Register addresses
   ////////////////////

   // Write-only control register
   localparam logic [2:0] REG_CS1 = 3'd0;
   // Read-only drive status
   localparam logic [2:0] REG_DS  = 3'd1;
   // Read-only look-ahead
   localparam logic [2:0] REG_LA  = 3'd2;
   // Maintenance register
   localparam logic [2:0] REG_MR  = 3'd3;

   ////////////////////
   // Field layout
   ////////////////////

   // CS1 function field in bits 5:1
   localparam int FUNC_LSB   = 1;
   localparam int FUNC_WIDTH = 5;
   // Drive clear function code
   localparam logic [FUNC_WIDTH-1:0] FUNC_DRVCLR = 5'o04;

   // MR bit positions
   localparam int MR_DMD  = 0;
   localparam int MR_DCLK = 1;
   localparam int MR_DIND = 2;
   localparam int MR_DSCK = 3;
   localparam int MR_DDAT = 4;

   // DS bit positions
   localparam int DS_DRY = 7;
   localparam int DS_DMD = 0;

   // Sector field inside LA
   localparam int LA_LSB = 6;

   // Bus and register widths
   localparam int DATA_WIDTH = 36;
   localparam int MR_WIDTH   = 16;

endpackage

`default_nettype wire

// ==== hdl/rpSectorTimer.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpSectorTimer (
   input  wire     clk,
   input  wire     rst,
   rpRegBus.timer  bus
);

   logic [rpTimingPkg::PRESCALE_WIDTH-1:0] prescale;
   logic [rpTimingPkg::SECTOR_WIDTH-1:0]   sector;
   logic dsckQ;
   logic dindQ;
   logic diagMode;
   logic dsckRise;
   logic dindRise;
   logic prescaleDone;

   // Next sector, wrapping at end of track
   function automatic logic [rpTimingPkg::SECTOR_WIDTH-1:0] stepSector(
      input logic [rpTimingPkg::SECTOR_WIDTH-1:0] cur
   );
      if (cur == rpTimingPkg::SECTOR_WIDTH'(rpTimingPkg::SECTORS - 1))
         return '0;
      else
         return cur + 1'b1;
   endfunction

   assign diagMode = bus.mr[rpRegPkg::MR_DMD];

   ////////////////////
   // Diagnostic edges
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dsckQ <= 1'b0;
         dindQ <= 1'b0;
      end
      else
      begin
         dsckQ <= bus.mr[rpRegPkg::MR_DSCK];
         dindQ <= bus.mr[rpRegPkg::MR_DIND];
      end
   end

   assign dsckRise = bus.mr[rpRegPkg::MR_DSCK] & ~dsckQ;
   assign dindRise = bus.mr[rpRegPkg::MR_DIND] & ~dindQ;

   ////////////////////
   // Prescaler
   ////////////////////

   assign prescaleDone =
      (prescale == rpTimingPkg::PRESCALE_WIDTH'(rpTimingPkg::SECTOR_CYCLES - 1));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         prescale <= '0;
      // Frozen in diagnostic mode
      else if (diagMode | prescaleDone)
         prescale <= '0;
      else
         prescale <= prescale + 1'b1;
   end

   ////////////////////
   // Sector counter
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         sector <= '0;
      else if (diagMode)
      begin
         // Index pulse wins over sector clock
         if (dindRise)
            sector <= '0;
         else if (dsckRise)
            sector <= stepSector(sector);
      end
      else if (prescaleDone)
         sector <= stepSector(sector);
   end

   assign bus.sector = sector;

endmodule

`default_nettype wire

// ==== hdl/rpTimingPkg.sv ====
`default_nettype none

package rpTimingPkg;

   ////////////////////
   // Drive geometry
   ////////////////////

   // Sectors per track
   localparam int SECTORS      = 20;
   localparam int SECTOR_WIDTH = 5;

   // Clocks per sector in normal mode
   localparam int SECTOR_CYCLES  = 16;
   localparam int PRESCALE_WIDTH = $clog2(SECTOR_CYCLES);

   ////////////////////
   // Handshake states
   ////////////////////

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      ACKING
   } accessState_t;

endpackage

`default_nettype wire

// ==== sim/rpDriveTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpDriveTb;

   logic clk;
   logic rst;
   logic clr;
   logic drvReady;
   logic req;
   logic write;
   logic [2:0] addr;
   logic [rpRegPkg::DATA_WIDTH-1:0] wrData;
   wire ack;
   wire [rpRegPkg::DATA_WIDTH-1:0] rdData;

   // Packed rows of op, addr, ready, wrData and expected
   logic [83:0] vectors [0:63];
   int errors;
   int checks;
   bit timedOut;

   rpDrive u_dut (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .drvReady (drvReady),
      .req      (req),
      .write    (write),
      .addr     (addr),
      .wrData   (wrData),
      .ack      (ack),
      .rdData   (rdData)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic checkValue(input string testName, input logic [35:0] expected,
                             input logic [35:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Fail %s: expected %h, actual %h", testName, expected, actual);
      end
   endtask

   // Ack level sampled on each rising edge for up to 20 clocks
   task automatic waitAck(input logic level);
      int count;
      count = 0;
      do
      begin
         @(posedge clk);
         count++;
      end
      while (ack !== level && count < 20);
      if (ack !== level)
      begin
         timedOut = 1'b1;
         errors++;
         $display("Timeout: ack did not go to %0d within 20 clocks", level);
      end
   endtask

   // One four-phase access and a short random idle gap
   task automatic regAccess(input logic wr, input logic [2:0] a,
                            input logic [35:0] d, output logic [35:0] rd);
      @(posedge clk);
      req    <= 1'b1;
      write  <= wr;
      addr   <= a;
      wrData <= d;
      waitAck(1'b1);
      // Held while ack is high
      rd = rdData;
      req <= 1'b0;
      waitAck(1'b0);
      repeat ($urandom_range(3, 0)) @(posedge clk);
   endtask

   task automatic pulseClr;
      @(posedge clk);
      clr <= 1'b1;
      @(posedge clk);
      clr <= 1'b0;
   endtask

   // DSCK low then high with DMD kept set
   task automatic stepDiagClock(input int pairs);
      logic [35:0] unused;
      logic [35:0] dsckLow;
      dsckLow = 36'd1 << rpRegPkg::MR_DMD;
      for (int i = 0; i < pairs; i++)
      begin
         regAccess(1'b1, rpRegPkg::REG_MR, dsckLow, unused);
         regAccess(1'b1, rpRegPkg::REG_MR, dsckLow | (36'd1 << rpRegPkg::MR_DSCK), unused);
      end
   endtask

   // Free-running sector in normal mode
   task automatic checkTimer;
      logic [35:0] first;
      logic [35:0] second;
      int sectorA;
      int sectorB;
      // Enough read pairs to span more than one revolution
      for (int n = 0; n < rpTimingPkg::SECTORS; n++)
      begin
         regAccess(1'b0, rpRegPkg::REG_LA, '0, first);
         // More than one sector period between the reads
         repeat (rpTimingPkg::SECTOR_CYCLES + 2) @(posedge clk);
         regAccess(1'b0, rpRegPkg::REG_LA, '0, second);
         sectorA = int'(first[rpRegPkg::LA_LSB +: rpTimingPkg::SECTOR_WIDTH]);
         sectorB = int'(second[rpRegPkg::LA_LSB +: rpTimingPkg::SECTOR_WIDTH]);
         checkValue("timer range", 36'd1, 36'(sectorA < rpTimingPkg::SECTORS));
         checkValue("timer range", 36'd1, 36'(sectorB < rpTimingPkg::SECTORS));
         checkValue("timer advance", 36'd1, 36'(sectorA != sectorB));
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      logic [83:0] vec;
      logic [35:0] rd;
      int idx;
      errors   = 0;
      checks   = 0;
      timedOut = 1'b0;
      void'($urandom(81596));
      rst      <= 1'b1;
      clr      <= 1'b0;
      drvReady <= 1'b0;
      req      <= 1'b0;
      write    <= 1'b0;
      addr     <= '0;
      wrData   <= '0;
      // Zero rows end the list
      for (idx = 0; idx < 64; idx++)
         vectors[idx] = '0;
      $readmemh("sim/rpDrive_vectors.txt", vectors);
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      checkValue("ack after reset", 36'd0, 36'(ack));
      checkValue("rdData after reset", 36'd0, rdData);
      // Drive not ready reads DRY clear
      regAccess(1'b0, rpRegPkg::REG_DS, '0, rd);
      checkValue("DS not ready", 36'd0, rd);
      idx = 0;
      while (idx < 64 && vectors[idx][83:80] != 4'h0 && !timedOut)
      begin
         vec = vectors[idx];
         drvReady <= vec[72];
         case (vec[83:80])
            4'h1: regAccess(1'b1, vec[78:76], vec[71:36], rd);
            4'h2:
            begin
               regAccess(1'b0, vec[78:76], vec[71:36], rd);
               checkValue($sformatf("vector %0d read", idx), vec[35:0], rd);
            end
            4'h3: pulseClr();
            4'h4: checkTimer();
            4'h5: stepDiagClock(int'(vec[43:36]));
            default:
            begin
               errors++;
               $display("Vector %0d has an unknown operation code", idx);
            end
         endcase
         idx++;
      end
      if (idx == 0)
      begin
         errors++;
         $display("No vectors were read from the vector file");
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/rpDrive_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module rpDriveProperties (
   input wire                           clk,
   input wire                           rst,
   input wire                           req,
   input wire                           ack,
   input wire [rpRegPkg::MR_WIDTH-1:0]  mr
);

   logic [3:0] diagBits;

   assign diagBits = {mr[rpRegPkg::MR_DDAT], mr[rpRegPkg::MR_DSCK],
                      mr[rpRegPkg::MR_DIND], mr[rpRegPkg::MR_DCLK]};

   ////////////////////
   // Handshake
   ////////////////////

   // Ack only rises into an active request
   ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
      else $error("ack rose while req was low");

   // Release one clock after req drops
   ackRelease: assert property (@(posedge clk) disable iff (rst) $fell(req) |=> !ack)
      else $error("ack still high one clock after req fell");

   ////////////////////
   // MR gating
   ////////////////////

   // Diag bits follow DMD one clock later
   diagGated: assert property (@(posedge clk) disable iff (rst)
      !mr[rpRegPkg::MR_DMD] |=> (diagBits == 4'b0))
      else $error("diagnostic MR bits set while DMD clear");

endmodule

bind rpDrive rpDriveProperties driveProps (
   .clk (clk),
   .rst (rst),
   .req (req),
   .ack (ack),
   .mr  (bus.mr)
);

`default_nettype wire

// ==== sim/rpDrive_vectors.txt ====
// Columns op_addr_ready_wrData_expected, all hex; expected only used by op 2
// Op 1 write, 2 read and compare, 3 clr pulse, 4 normal timer check, 5 DSCK pairs
2_3_0_000000000_000000000
2_1_1_000000000_000000080
1_3_0_00000001F_000000000
2_3_0_000000000_000000000
1_3_1_00000001E_000000000
2_3_1_000000000_000000000
1_3_1_000000001_000000000
1_3_1_00000001F_000000000
2_3_1_000000000_00000001F
2_1_1_000000000_000000081
1_0_1_000000002_000000000
2_3_1_000000000_00000001F
2_0_1_000000000_000000000
1_0_1_000000008_000000000
2_3_1_000000000_000000000
1_3_1_000000001_000000000
1_3_1_00000001F_000000000
3_0_1_000000000_000000000
2_3_1_000000000_000000000
1_3_1_000000001_000000000
1_3_1_000000005_000000000
2_2_1_000000000_000000000
5_0_1_000000001_000000000
2_2_1_000000000_000000040
5_0_1_000000012_000000000
2_2_1_000000000_0000004C0
5_0_1_000000001_000000000
2_2_1_000000000_000000000
3_0_1_000000000_000000000
4_0_1_000000000_000000000
0_0_0_000000000_000000000

// ==== sources.f ====
hdl/rpRegPkg.sv
hdl/rpTimingPkg.sv
hdl/rpRegBus.sv
hdl/rpRegAccessFsm.sv
hdl/rpSectorTimer.sv
hdl/rpMaintReg.sv
hdl/rpDrive.sv
sim/rpDrive_properties.sv
sim/rpDriveTb.sv
